/* Bender.yml */
package:
  name: rs_issue_stage

sources:
  - files:
      - logic/rs_cfg_pkg.sv
      - logic/rs_op_pkg.sv
      - logic/rs_dispatch.sv
      - logic/rs_station.sv
      - logic/rs_issue.sv
      - logic/rs_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/rs_tb.sv

/* include/rs_tb_table.svh */
`ifndef rs_tb_table_svh
`define rs_tb_table_svh
// stim: dispatch_valid, is_muldiv, funct3, alt, ps1, ps1_rdy, ps2, ps2_rdy, pd, rob,
//       cdb_valid, cdb_tag, add_fu_busy, muldiv_fu_busy
// expect: add_full, muldiv_full, add {valid, ps1, ps2, pd, rob, op}, muldiv {same}

stim_q.push_back('0);                                                   // state after reset
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 0, 3'b000, 1, 1, 1, 2, 1, 10, 1, 0, 0, 0, 0});    // sub
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 0, 3'b101, 1, 3, 1, 4, 1, 11, 2, 0, 0, 0, 0});    // sra
exp_q.push_back(expect_t'{0, 0, '{1, 1, 2, 10, 1, 5'b10000}, '0});
stim_q.push_back(stim_t'{1, 0, 3'b100, 0, 40, 1, 41, 0, 12, 3, 0, 0, 0, 0});  // xor, ps2 pending
exp_q.push_back(expect_t'{0, 0, '{1, 3, 4, 11, 2, 5'b11010}, '0});

// multiply/divide decode, one in and one out per cycle
stim_q.push_back(stim_t'{1, 1, 3'b000, 0, 16, 1, 24, 1, 32, 8, 0, 0, 0, 0});  // mul
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 1, 3'b001, 0, 17, 1, 25, 1, 33, 9, 0, 41, 0, 0}); // tag 41, no valid
exp_q.push_back(expect_t'{0, 0, '0, '{1, 16, 24, 32, 8, 5'b00110}});
stim_q.push_back(stim_t'{1, 1, 3'b010, 0, 18, 1, 26, 1, 34, 10, 0, 0, 0, 0}); // mulhsu
exp_q.push_back(expect_t'{0, 0, '0, '{1, 17, 25, 33, 9, 5'b01110}});
stim_q.push_back(stim_t'{1, 1, 3'b011, 0, 19, 1, 27, 1, 35, 11, 1, 41, 0, 0}); // wakes the xor
exp_q.push_back(expect_t'{0, 0, '0, '{1, 18, 26, 34, 10, 5'b01100}});
stim_q.push_back(stim_t'{1, 1, 3'b100, 0, 20, 1, 28, 1, 36, 12, 0, 0, 0, 0}); // div
exp_q.push_back(expect_t'{0, 0, '0, '{1, 19, 27, 35, 11, 5'b01000}});
stim_q.push_back(stim_t'{1, 1, 3'b101, 0, 21, 1, 29, 1, 37, 13, 0, 0, 0, 0}); // divu
exp_q.push_back(expect_t'{0, 0, '{1, 40, 41, 12, 3, 5'b01000}, '{1, 20, 28, 36, 12, 5'b10110}});
stim_q.push_back(stim_t'{1, 1, 3'b110, 0, 22, 1, 30, 1, 38, 14, 0, 0, 0, 0}); // rem
exp_q.push_back(expect_t'{0, 0, '0, '{1, 21, 29, 37, 13, 5'b10000}});
stim_q.push_back(stim_t'{1, 1, 3'b111, 0, 23, 1, 31, 1, 39, 15, 0, 0, 0, 0}); // remu
exp_q.push_back(expect_t'{0, 0, '0, '{1, 22, 30, 38, 14, 5'b11110}});

// add unit busy while three ready adds arrive
stim_q.push_back(stim_t'{1, 0, 3'b000, 0, 1, 1, 2, 1, 13, 16, 0, 0, 1, 0});
exp_q.push_back(expect_t'{0, 0, '0, '{1, 23, 31, 39, 15, 5'b11000}});
stim_q.push_back(stim_t'{1, 0, 3'b001, 0, 3, 1, 4, 1, 14, 17, 0, 0, 1, 0});   // sll
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 0, 3'b111, 0, 5, 1, 6, 1, 15, 18, 0, 0, 1, 0});   // and
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 1, 3'b000, 0, 44, 1, 50, 0, 45, 19, 0, 0, 1, 0}); // mul waits on 50
exp_q.push_back('0);
stim_q.push_back(stim_t'{1, 1, 3'b100, 0, 46, 1, 51, 0, 47, 20, 0, 0, 0, 0}); // div waits on 51
exp_q.push_back(expect_t'{0, 0, '{1, 1, 2, 13, 16, 5'b00000}, '0});

// muldiv station full, this one is dropped
stim_q.push_back(stim_t'{1, 1, 3'b001, 0, 52, 1, 53, 1, 54, 21, 1, 50, 0, 0});
exp_q.push_back(expect_t'{0, 1, '{1, 3, 4, 14, 17, 5'b00010}, '0});
stim_q.push_back('0);
exp_q.push_back(expect_t'{0, 1, '{1, 5, 6, 15, 18, 5'b01110}, '0});
stim_q.push_back('0);                                                   // woken mul issues
exp_q.push_back(expect_t'{0, 1, '0, '{1, 44, 50, 45, 19, 5'b00110}});
stim_q.push_back('0);
exp_q.push_back('0);
stim_q.push_back('0);
exp_q.push_back('0);
`endif

/* dv/rs_tb.sv */
module rs_tb;

    import rs_cfg_pkg::*;
    import rs_op_pkg::*;

    localparam int reset_cycles = 5;

    // member order matches the columns of the table
    typedef struct packed {
        logic       dispatch_valid;
        logic       is_muldiv;
        logic [2:0] funct3;
        logic       alt;
        ptag_t      ps1;
        logic       ps1_rdy;
        ptag_t      ps2;
        logic       ps2_rdy;
        ptag_t      pd;
        rob_idx_t   rob;
        logic       cdb_valid;
        ptag_t      cdb_tag;
        logic       add_fu_busy;
        logic       muldiv_fu_busy;
    } stim_t;

    typedef struct packed {
        logic     valid;
        ptag_t    ps1;
        ptag_t    ps2;
        ptag_t    pd;
        rob_idx_t rob;
        rs_op_u   op;
    } issue_t;

    typedef struct packed {
        logic   add_full;
        logic   muldiv_full;
        issue_t add;
        issue_t muldiv;
    } expect_t;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       dispatch_valid, is_muldiv, alt, ps1_rdy, ps2_rdy;
    logic [2:0] funct3;
    ptag_t      ps1, ps2, pd, cdb_tag;
    rob_idx_t   rob;
    logic       cdb_valid, add_fu_busy, muldiv_fu_busy;
    logic       add_full, muldiv_full, add_issue_valid, muldiv_issue_valid;
    ptag_t      add_ps1, add_ps2, add_pd, muldiv_ps1, muldiv_ps2, muldiv_pd;
    rob_idx_t   add_rob, muldiv_rob;
    rs_op_u     add_op, muldiv_op;

    stim_t   stim_q [$];
    expect_t exp_q [$];
    int      row_idx = 0;
    int      cycle_count = 0;

    rs_top #(
        .add_depth    (4),
        .muldiv_depth (2)
    ) i_dut (.*);

    always #5 clk = ~clk;

    task automatic load_table();
        `include "rs_tb_table.svh"
    endtask

    task automatic apply_stim(input stim_t s);
        {dispatch_valid, is_muldiv, funct3, alt, ps1, ps1_rdy, ps2, ps2_rdy, pd, rob,
         cdb_valid, cdb_tag, add_fu_busy, muldiv_fu_busy} = s;
    endtask

    task automatic end_with_failure(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t row %0d: %s is %b, expected %b", $time, row_idx, name, got, exp);
            end_with_failure("output mismatch");
        end
    endtask

    task automatic check_tag(input string name, input ptag_t got, input ptag_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t row %0d: %s is %0d, expected %0d", $time, row_idx, name, got, exp);
            end_with_failure("output mismatch");
        end
    endtask

    task automatic check_op(input string name, input rs_op_u got, input rs_op_u exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t row %0d: %s is %b, expected %b", $time, row_idx, name, got, exp);
            end_with_failure("output mismatch");
        end
    endtask

    task automatic verify_outputs(input expect_t e);
        check_flag("add_full", add_full, e.add_full);
        check_flag("muldiv_full", muldiv_full, e.muldiv_full);
        check_flag("add_issue_valid", add_issue_valid, e.add.valid);
        check_tag("add_ps1", add_ps1, e.add.ps1);
        check_tag("add_ps2", add_ps2, e.add.ps2);
        check_tag("add_pd", add_pd, e.add.pd);
        check_tag("add_rob", add_rob, e.add.rob);
        check_op("add_op", add_op, e.add.op);
        check_flag("muldiv_issue_valid", muldiv_issue_valid, e.muldiv.valid);
        check_tag("muldiv_ps1", muldiv_ps1, e.muldiv.ps1);
        check_tag("muldiv_ps2", muldiv_ps2, e.muldiv.ps2);
        check_tag("muldiv_pd", muldiv_pd, e.muldiv.pd);
        check_tag("muldiv_rob", muldiv_rob, e.muldiv.rob);
        check_op("muldiv_op", muldiv_op, e.muldiv.op);
    endtask

    initial
    begin
        apply_stim('0);
        load_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // one row per cycle, driven on the falling edge
        for (row_idx = 0; row_idx < stim_q.size(); row_idx++)
        begin
            apply_stim(stim_q[row_idx]);
            #2;  // settled, rising edge is 3 units away
            verify_outputs(exp_q[row_idx]);
            @(negedge clk);
        end
        $display("test passed");
        $finish;
    end

    // table rows, reset and some slack
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > stim_q.size() + reset_cycles + 20)
        begin
            $display("timeout: the table did not finish within %0d cycles", cycle_count - 1);
            end_with_failure("simulation ran too long");
        end
    end

endmodule : rs_tb

/* flist.f */
+incdir+include
logic/rs_cfg_pkg.sv
logic/rs_op_pkg.sv
logic/rs_dispatch.sv
logic/rs_station.sv
logic/rs_issue.sv
logic/rs_top.sv
dv/rs_tb.sv

/* logic/rs_cfg_pkg.sv */
package rs_cfg_pkg;

    // physical register file is 64 deep
    parameter int ptag_w = 6;

    // reorder buffer index, 64 slots
    parameter int rob_w = 6;

    // tag carried by the source and destination fields and by the cdb
    typedef logic [ptag_w-1:0] ptag_t;

    typedef logic [rob_w-1:0] rob_idx_t;

    // station depths used when the top level is not overridden
    parameter int add_depth_default    = 4;  // add/logic class
    parameter int muldiv_depth_default = 2;  // multiply/divide class

endpackage : rs_cfg_pkg

/* logic/rs_dispatch.sv */
module rs_dispatch
(
    input  logic                   dispatch_valid,
    input  logic                   is_muldiv,
    input  logic [2:0]             funct3,
    input  logic                   alt,        // funct7 bit 5
    input  rs_cfg_pkg::ptag_t      ps1,
    input  logic                   ps1_rdy,
    input  rs_cfg_pkg::ptag_t      ps2,
    input  logic                   ps2_rdy,
    input  rs_cfg_pkg::ptag_t      pd,
    input  rs_cfg_pkg::rob_idx_t   rob,
    input  logic                   add_full,
    input  logic                   muldiv_full,
    output rs_op_pkg::rs_entry_t   entry,
    output logic                   add_insert,
    output logic                   muldiv_insert
);

    import rs_op_pkg::*;

    op_class_e cls;
    rs_op_u    op;

    assign cls = op_class_e'(is_muldiv);

    // decode funct3/alt into the view that the target station reads
    always_comb
    begin
        op = '0;
        if (cls == cls_add)
        begin
            op.alu.alu_op = alu_op_e'({alt, funct3});
            op.alu.spare  = 1'b0;
        end
        else if (!funct3[2])
        begin
            // mul, mulh, mulhsu, mulhu
            op.muldiv.is_div       = 1'b0;
            op.muldiv.upper_or_rem = (funct3[1:0] != 2'b00);
            op.muldiv.signed_a     = (funct3[1:0] != 2'b11);
            op.muldiv.signed_b     = !funct3[1];
            op.muldiv.spare        = 1'b0;
        end
        else
        begin
            // div, divu, rem, remu
            op.muldiv.is_div       = 1'b1;
            op.muldiv.upper_or_rem = funct3[1];
            op.muldiv.signed_a     = !funct3[0];
            op.muldiv.signed_b     = !funct3[0];
            op.muldiv.spare        = 1'b0;
        end
    end

    always_comb
    begin
        entry.busy    = 1'b1;
        entry.ps1_rdy = ps1_rdy;
        entry.ps2_rdy = ps2_rdy;
        entry.ps1     = ps1;
        entry.ps2     = ps2;
        entry.pd      = pd;
        entry.rob     = rob;
        entry.op      = op;
    end

    // a full station drops the dispatch, the front end has to hold off
    assign add_insert    = dispatch_valid && (cls == cls_add) && !add_full;
    assign muldiv_insert = dispatch_valid && (cls == cls_muldiv) && !muldiv_full;

endmodule : rs_dispatch

/* logic/rs_issue.sv */
module rs_issue
#(
    parameter int depth = rs_cfg_pkg::add_depth_default
)
(
    input  logic                       [depth-1:0] ready,
    input  rs_op_pkg::rs_entry_t       entries [depth],
    input  logic                       fu_busy,
    output logic                       issue_valid,
    output logic [$clog2(depth)-1:0]   issue_idx,
    output rs_cfg_pkg::ptag_t          ps1,
    output rs_cfg_pkg::ptag_t          ps2,
    output rs_cfg_pkg::ptag_t          pd,
    output rs_cfg_pkg::rob_idx_t       rob,
    output rs_op_pkg::rs_op_u          op
);

    import rs_op_pkg::*;

    localparam int idx_w = $clog2(depth);

    logic [idx_w-1:0] sel_idx;
    logic             found;
    rs_entry_t        sel;

    // oldest-slot-first priority, lowest index wins
    always_comb
    begin
        sel_idx = '0;
        found   = 1'b0;
        for (int i = depth - 1; i >= 0; i--)
        begin
            if (ready[i])
            begin
                sel_idx = idx_w'(i);
                found   = 1'b1;
            end
        end
    end

    assign issue_valid = found && !fu_busy;   // busy unit holds everything
    assign issue_idx   = issue_valid ? sel_idx : '0;

    always_comb
    begin
        sel = '0;
        if (issue_valid)
            sel = entries[sel_idx];
    end

    assign ps1 = sel.ps1;
    assign ps2 = sel.ps2;
    assign pd  = sel.pd;
    assign rob = sel.rob;
    assign op  = sel.op;

    // the station's ready vector has to agree with the entry state it exports
    always_comb
    begin
        assert final (!issue_valid || (entries[issue_idx].busy
                                       && entries[issue_idx].ps1_rdy
                                       && entries[issue_idx].ps2_rdy))
            else $error("rs_issue: issued slot %0d is not ready", issue_idx);
    end

endmodule : rs_issue

/* logic/rs_op_pkg.sv */
package rs_op_pkg;

    import rs_cfg_pkg::*;

    // which station a micro-op goes to
    typedef enum logic {
        cls_add    = 1'b0,
        cls_muldiv = 1'b1
    } op_class_e;

    // {funct7[5], funct3} of the rv32 integer ops
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    spare;         // always zero
    } alu_view_t;

    typedef struct packed {
        logic is_div;
        logic upper_or_rem;     // mulh* for multiply, rem* for divide
        logic signed_a;
        logic signed_b;
        logic spare;            // always zero
    } muldiv_view_t;

    // one 5-bit operation word, read according to the station holding it
    typedef union packed {
        alu_view_t    alu;
        muldiv_view_t muldiv;
    } rs_op_u;

    typedef struct packed {
        logic     busy;
        logic     ps1_rdy;
        logic     ps2_rdy;
        ptag_t    ps1;
        ptag_t    ps2;
        ptag_t    pd;
        rob_idx_t rob;
        rs_op_u   op;
    } rs_entry_t;

endpackage : rs_op_pkg

/* logic/rs_station.sv */
module rs_station
#(
    parameter int depth = rs_cfg_pkg::add_depth_default
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       insert,
    input  rs_op_pkg::rs_entry_t       entry_in,
    input  logic                       cdb_valid,
    input  rs_cfg_pkg::ptag_t          cdb_tag,
    input  logic                       issue_valid,
    input  logic [$clog2(depth)-1:0]   issue_idx,
    output logic                       full,
    output logic [depth-1:0]           ready,
    output rs_op_pkg::rs_entry_t       entries [depth]
);

    import rs_cfg_pkg::*;
    import rs_op_pkg::*;

    localparam int idx_w = $clog2(depth);

    if (depth < 2)
    begin : g_depth_check
        $error("rs_station: depth must be at least 2");
    end

    // control bits per slot
    logic [depth-1:0] busy_q;
    logic [depth-1:0] ps1_rdy_q;
    logic [depth-1:0] ps2_rdy_q;

    rs_entry_t slot_q [depth];      // tags, rob index and op word

    logic  cdb_valid_q;
    ptag_t cdb_tag_q;

    logic [idx_w-1:0] free_idx;
    logic [depth-1:0] wake1;
    logic [depth-1:0] wake2;
    logic             ins_wake1;
    logic             ins_wake2;

    // lowest free slot, scanned from the top so the last hit wins
    always_comb
    begin
        free_idx = '0;
        full     = 1'b1;
        for (int i = depth - 1; i >= 0; i--)
        begin
            if (!busy_q[i])
            begin
                free_idx = idx_w'(i);
                full     = 1'b0;
            end
        end
    end

    // wakeup compare against last cycle's cdb
    always_comb
    begin
        for (int i = 0; i < depth; i++)
        begin
            wake1[i] = cdb_valid_q && (slot_q[i].ps1 == cdb_tag_q);
            wake2[i] = cdb_valid_q && (slot_q[i].ps2 == cdb_tag_q);
        end
    end

    assign ins_wake1 = cdb_valid_q && (entry_in.ps1 == cdb_tag_q);
    assign ins_wake2 = cdb_valid_q && (entry_in.ps2 == cdb_tag_q);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q      <= '0;
            ps1_rdy_q   <= '0;
            ps2_rdy_q   <= '0;
            cdb_valid_q <= 1'b0;
        end
        else
        begin
            cdb_valid_q <= cdb_valid;
            for (int i = 0; i < depth; i++)
            begin
                if (busy_q[i] && wake1[i])
                    ps1_rdy_q[i] <= 1'b1;
                if (busy_q[i] && wake2[i])
                    ps2_rdy_q[i] <= 1'b1;
            end
            if (insert)
            begin
                busy_q[free_idx]    <= 1'b1;
                ps1_rdy_q[free_idx] <= entry_in.ps1_rdy || ins_wake1;
                ps2_rdy_q[free_idx] <= entry_in.ps2_rdy || ins_wake2;
            end
            // issued slot is always busy, never the free one
            if (issue_valid)
                busy_q[issue_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        cdb_tag_q <= cdb_tag;
        if (insert)
            slot_q[free_idx] <= entry_in;
    end

    always_comb
    begin
        for (int i = 0; i < depth; i++)
        begin
            entries[i]         = slot_q[i];
            entries[i].busy    = busy_q[i];
            entries[i].ps1_rdy = ps1_rdy_q[i];
            entries[i].ps2_rdy = ps2_rdy_q[i];
        end
    end

    assign ready = busy_q & ps1_rdy_q & ps2_rdy_q;

    // dispatch must have seen the full flag
    a_no_insert_when_full: assert property (
        @(posedge clk) disable iff (rst) !(insert && full)
    ) else $error("rs_station: insert while full");

endmodule : rs_station

/* logic/rs_top.sv */
module rs_top
#(
    parameter int add_depth    = rs_cfg_pkg::add_depth_default,
    parameter int muldiv_depth = rs_cfg_pkg::muldiv_depth_default
)
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   dispatch_valid,
    input  logic                   is_muldiv,
    input  logic [2:0]             funct3,
    input  logic                   alt,
    input  rs_cfg_pkg::ptag_t      ps1,
    input  logic                   ps1_rdy,
    input  rs_cfg_pkg::ptag_t      ps2,
    input  logic                   ps2_rdy,
    input  rs_cfg_pkg::ptag_t      pd,
    input  rs_cfg_pkg::rob_idx_t   rob,

    input  logic                   cdb_valid,
    input  rs_cfg_pkg::ptag_t      cdb_tag,
    input  logic                   add_fu_busy,
    input  logic                   muldiv_fu_busy,

    output logic                   add_full,
    output logic                   muldiv_full,

    output logic                   add_issue_valid,
    output rs_cfg_pkg::ptag_t      add_ps1,
    output rs_cfg_pkg::ptag_t      add_ps2,
    output rs_cfg_pkg::ptag_t      add_pd,
    output rs_cfg_pkg::rob_idx_t   add_rob,
    output rs_op_pkg::rs_op_u      add_op,

    output logic                   muldiv_issue_valid,
    output rs_cfg_pkg::ptag_t      muldiv_ps1,
    output rs_cfg_pkg::ptag_t      muldiv_ps2,
    output rs_cfg_pkg::ptag_t      muldiv_pd,
    output rs_cfg_pkg::rob_idx_t   muldiv_rob,
    output rs_op_pkg::rs_op_u      muldiv_op
);

    import rs_op_pkg::*;

    rs_entry_t entry;       // shared by both stations, one strobe picks
    logic      add_insert;
    logic      muldiv_insert;

    logic [add_depth-1:0]            add_ready;
    rs_entry_t                       add_entries [add_depth];
    logic [$clog2(add_depth)-1:0]    add_issue_idx;

    logic [muldiv_depth-1:0]         muldiv_ready;
    rs_entry_t                       muldiv_entries [muldiv_depth];
    logic [$clog2(muldiv_depth)-1:0] muldiv_issue_idx;

    rs_dispatch i_dispatch (
        .dispatch_valid (dispatch_valid),
        .is_muldiv      (is_muldiv),
        .funct3         (funct3),
        .alt            (alt),
        .ps1            (ps1),
        .ps1_rdy        (ps1_rdy),
        .ps2            (ps2),
        .ps2_rdy        (ps2_rdy),
        .pd             (pd),
        .rob            (rob),
        .add_full       (add_full),
        .muldiv_full    (muldiv_full),
        .entry          (entry),
        .add_insert     (add_insert),
        .muldiv_insert  (muldiv_insert)
    );

    // add/logic class
    rs_station #(.depth(add_depth)) i_add_station (
        .clk         (clk),
        .rst         (rst),
        .insert      (add_insert),
        .entry_in    (entry),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .issue_valid (add_issue_valid),
        .issue_idx   (add_issue_idx),
        .full        (add_full),
        .ready       (add_ready),
        .entries     (add_entries)
    );

    rs_issue #(.depth(add_depth)) i_add_issue (
        .ready       (add_ready),
        .entries     (add_entries),
        .fu_busy     (add_fu_busy),
        .issue_valid (add_issue_valid),
        .issue_idx   (add_issue_idx),
        .ps1         (add_ps1),
        .ps2         (add_ps2),
        .pd          (add_pd),
        .rob         (add_rob),
        .op          (add_op)
    );

    // multiply/divide class
    rs_station #(.depth(muldiv_depth)) i_muldiv_station (
        .clk         (clk),
        .rst         (rst),
        .insert      (muldiv_insert),
        .entry_in    (entry),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .issue_valid (muldiv_issue_valid),
        .issue_idx   (muldiv_issue_idx),
        .full        (muldiv_full),
        .ready       (muldiv_ready),
        .entries     (muldiv_entries)
    );

    rs_issue #(.depth(muldiv_depth)) i_muldiv_issue (
        .ready       (muldiv_ready),
        .entries     (muldiv_entries),
        .fu_busy     (muldiv_fu_busy),
        .issue_valid (muldiv_issue_valid),
        .issue_idx   (muldiv_issue_idx),
        .ps1         (muldiv_ps1),
        .ps2         (muldiv_ps2),
        .pd          (muldiv_pd),
        .rob         (muldiv_rob),
        .op          (muldiv_op)
    );

endmodule : rs_top
